// ==== logic/wb_bus_pkg.sv ====
package wb_bus_pkg;

    // Byte addressing on the bus.
    localparam int WB_ADDR_WIDTH = 32;

    // One beat carries a halfword.
    localparam int WB_DATA_WIDTH = 16;

    localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;
    localparam int WB_BEAT_BYTES = WB_SEL_WIDTH;      // Address step between beats.
    localparam int WB_BEAT_SHIFT = $clog2(WB_BEAT_BYTES);

    // The SRAM slave wraps its byte address modulo this many halfwords.
    localparam int WB_SRAM_WORDS     = 128;
    localparam int WB_SRAM_IDX_WIDTH = $clog2(WB_SRAM_WORDS);

    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
    typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;
    typedef logic [WB_SEL_WIDTH-1:0]  wb_sel_t;

endpackage

// ==== logic/drv_cmd_pkg.sv ====
package drv_cmd_pkg;

    // Host word as seen on the plain strobe interface.
    localparam int DRV_DATA_WIDTH = 32;

    localparam int DRV_NUM_BEATS  = DRV_DATA_WIDTH / wb_bus_pkg::WB_DATA_WIDTH;

    // Counters must reach DRV_NUM_BEATS itself, not just DRV_NUM_BEATS - 1.
    localparam int DRV_CNT_WIDTH  = $clog2(DRV_NUM_BEATS + 1);

    typedef logic [DRV_DATA_WIDTH-1:0] drv_data_t;

    typedef enum logic [1:0] {
        DRV_ST_IDLE = 2'b00,
        DRV_ST_REQS = 2'b01,
        DRV_ST_ACKS = 2'b10
    } drv_state_t;

endpackage

// ==== logic/wb_bus_if.sv ====
interface wb_bus_if;

    logic                 cyc;
    logic                 stb;
    logic                 we;
    wb_bus_pkg::wb_sel_t  sel;
    wb_bus_pkg::wb_addr_t addr;
    wb_bus_pkg::wb_data_t wdata;
    wb_bus_pkg::wb_data_t rdata;
    logic                 ack;
    logic                 stall;

    modport master (
        output cyc,
        output stb,
        output we,
        output sel,
        output addr,
        output wdata,
        input  rdata,
        input  ack,
        input  stall
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  sel,
        input  addr,
        input  wdata,
        output rdata,
        output ack,
        output stall
    );

endinterface

// ==== logic/wb_master_driver.sv ====
module wb_master_driver (
    input  logic                   i_wb_clk,
    input  logic                   i_wb_rst,

    wb_bus_if.master               wb,

    input  logic                   i_drv_en,
    input  logic                   i_drv_we,
    input  wb_bus_pkg::wb_addr_t   i_drv_addr,
    input  drv_cmd_pkg::drv_data_t i_drv_data,
    output drv_cmd_pkg::drv_data_t o_drv_data,
    output logic                   o_drv_done,
    output logic                   o_drv_busy
);

    drv_cmd_pkg::drv_state_t               state_q;
    drv_cmd_pkg::drv_state_t               state_d;

    logic [drv_cmd_pkg::DRV_CNT_WIDTH-1:0] req_cnt_q;
    logic [drv_cmd_pkg::DRV_CNT_WIDTH-1:0] ack_cnt_q;

    logic                                  drv_we_q;
    wb_bus_pkg::wb_addr_t                  addr_q;
    drv_cmd_pkg::drv_data_t                wdata_q;
    drv_cmd_pkg::drv_data_t                rdata_q;

    logic                                  beat_acc;
    logic                                  last_req;
    logic                                  cmd_take;

    assign cmd_take = (state_q == drv_cmd_pkg::DRV_ST_IDLE) && i_drv_en;

    // Stb is only high inside a cycle, so cyc need not be checked again.
    assign beat_acc = wb.stb && !wb.stall;
    assign last_req = beat_acc &&
                      (req_cnt_q == drv_cmd_pkg::DRV_CNT_WIDTH'(drv_cmd_pkg::DRV_NUM_BEATS - 1));

    assign o_drv_busy = (state_q != drv_cmd_pkg::DRV_ST_IDLE);
    assign o_drv_done = (state_q == drv_cmd_pkg::DRV_ST_ACKS) &&
                        (ack_cnt_q == drv_cmd_pkg::DRV_CNT_WIDTH'(drv_cmd_pkg::DRV_NUM_BEATS));
    assign o_drv_data = rdata_q;

    assign wb.cyc   = (state_q != drv_cmd_pkg::DRV_ST_IDLE);
    assign wb.stb   = (state_q == drv_cmd_pkg::DRV_ST_REQS);
    assign wb.we    = drv_we_q;
    assign wb.sel   = '1;                  // Whole halfwords only.
    assign wb.addr  = addr_q;
    assign wb.wdata = wdata_q[wb_bus_pkg::WB_DATA_WIDTH-1:0];

    always_comb begin
        state_d = state_q;
        case (state_q)
            drv_cmd_pkg::DRV_ST_IDLE: begin
                if (i_drv_en) begin
                    state_d = drv_cmd_pkg::DRV_ST_REQS;
                end
            end
            drv_cmd_pkg::DRV_ST_REQS: begin
                if (last_req) begin
                    state_d = drv_cmd_pkg::DRV_ST_ACKS;
                end
            end
            drv_cmd_pkg::DRV_ST_ACKS: begin
                if (o_drv_done) begin
                    state_d = drv_cmd_pkg::DRV_ST_IDLE;
                end
            end
            default: begin
                state_d = drv_cmd_pkg::DRV_ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            state_q <= drv_cmd_pkg::DRV_ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst || (state_q == drv_cmd_pkg::DRV_ST_IDLE)) begin
            req_cnt_q <= '0;
        end else if (beat_acc) begin
            req_cnt_q <= req_cnt_q + 1'b1;
        end
    end

    // Write acks can already arrive while the last beat is still requested.
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst || (state_q == drv_cmd_pkg::DRV_ST_IDLE)) begin
            ack_cnt_q <= '0;
        end else if (wb.ack) begin
            ack_cnt_q <= ack_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (cmd_take) begin
            drv_we_q <= i_drv_we;
            addr_q   <= i_drv_addr;
            wdata_q  <= i_drv_data;
        end else if (beat_acc) begin
            addr_q   <= addr_q + wb_bus_pkg::WB_ADDR_WIDTH'(wb_bus_pkg::WB_BEAT_BYTES);
            wdata_q  <= wdata_q >> wb_bus_pkg::WB_DATA_WIDTH;   // Next halfword moves down.
        end
    end

    // The first returned halfword ends up in the low half.
    always_ff @(posedge i_wb_clk) begin
        if (wb.ack && !drv_we_q && (state_q != drv_cmd_pkg::DRV_ST_IDLE)) begin
            rdata_q <= {wb.rdata,
                        rdata_q[drv_cmd_pkg::DRV_DATA_WIDTH-1:wb_bus_pkg::WB_DATA_WIDTH]};
        end
    end

endmodule

// ==== logic/wb_sram_slave.sv ====
module wb_sram_slave (
    input  logic    i_wb_clk,
    input  logic    i_wb_rst,

    wb_bus_if.slave wb
);

    wb_bus_pkg::wb_data_t                     mem [wb_bus_pkg::WB_SRAM_WORDS];
    logic [wb_bus_pkg::WB_SRAM_IDX_WIDTH-1:0] mem_idx;

    logic                                     beat_acc;
    logic                                     wr_acc;
    logic                                     rd_acc;

    logic                                     wr_ack_q;
    logic                                     rd_pend_q;
    logic                                     rd_ack_q;
    wb_bus_pkg::wb_data_t                     rd_data_q;

    // Upper address bits are dropped, so the memory wraps.
    assign mem_idx = wb.addr[wb_bus_pkg::WB_BEAT_SHIFT +: wb_bus_pkg::WB_SRAM_IDX_WIDTH];

    assign beat_acc = wb.cyc && wb.stb && !rd_pend_q;
    assign wr_acc   = beat_acc && wb.we;
    assign rd_acc   = beat_acc && !wb.we;

    // A read in flight blocks the next beat for its wait state.
    assign wb.stall = rd_pend_q;
    assign wb.ack   = wr_ack_q || rd_ack_q;
    assign wb.rdata = rd_data_q;

    always_ff @(posedge i_wb_clk) begin
        if (wr_acc) begin
            mem[mem_idx] <= wb.wdata;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (rd_acc) begin
            rd_data_q <= mem[mem_idx];          // Held until the next read is accepted.
        end
    end

    // Writes ack from the first stage, reads from the second.
    // Stall keeps any following write from overtaking a pending read ack.
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            wr_ack_q  <= 1'b0;
            rd_pend_q <= 1'b0;
            rd_ack_q  <= 1'b0;
        end else begin
            wr_ack_q  <= wr_acc;
            rd_pend_q <= rd_acc;
            rd_ack_q  <= rd_pend_q;
        end
    end

endmodule

// ==== logic/wb_word_access.sv ====
module wb_word_access (
    input  logic                   i_wb_clk,
    input  logic                   i_wb_rst,

    input  logic                   i_drv_en,
    input  logic                   i_drv_we,
    input  wb_bus_pkg::wb_addr_t   i_drv_addr,
    input  drv_cmd_pkg::drv_data_t i_drv_data,
    output drv_cmd_pkg::drv_data_t o_drv_data,
    output logic                   o_drv_done,
    output logic                   o_drv_busy
);

    wb_bus_if wb_bus ();

    // Host side of the bus.
    wb_master_driver i_wb_master_driver (
        .i_wb_clk   (i_wb_clk),
        .i_wb_rst   (i_wb_rst),
        .wb         (wb_bus.master),
        .i_drv_en   (i_drv_en),
        .i_drv_we   (i_drv_we),
        .i_drv_addr (i_drv_addr),
        .i_drv_data (i_drv_data),
        .o_drv_data (o_drv_data),
        .o_drv_done (o_drv_done),
        .o_drv_busy (o_drv_busy)
    );

    wb_sram_slave i_wb_sram_slave (
        .i_wb_clk (i_wb_clk),
        .i_wb_rst (i_wb_rst),
        .wb       (wb_bus.slave)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic o_clk
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam time HALF_PERIOD = 50ns;

    initial begin
        o_clk = 1'b0;
        forever begin
            #HALF_PERIOD o_clk = ~o_clk;   // Gives the 100 ns period.
        end
    end

endmodule

// ==== sim/tb_wb_word_access.sv ====
module tb_wb_word_access;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DONE_TIMEOUT = 40;
    localparam int LFSR_ROWS    = 12;

    logic                   i_wb_clk;
    logic                   i_wb_rst;
    logic                   i_drv_en;
    logic                   i_drv_we;
    wb_bus_pkg::wb_addr_t   i_drv_addr;
    drv_cmd_pkg::drv_data_t i_drv_data;
    drv_cmd_pkg::drv_data_t o_drv_data;
    logic                   o_drv_done;
    logic                   o_drv_busy;

    // Stimulus table with one entry per row in each queue.
    string                  row_name[$];
    bit                     row_we[$];
    wb_bus_pkg::wb_addr_t   row_addr[$];
    bit                     row_lfsr[$];     // Write data is taken from the LFSR.
    drv_cmd_pkg::drv_data_t row_data[$];
    bit                     row_model[$];    // Expected read word comes from the shadow memory.
    drv_cmd_pkg::drv_data_t row_exp[$];
    bit                     row_poke[$];     // A second enable is pulsed while busy.

    wb_bus_pkg::wb_data_t   shadow [wb_bus_pkg::WB_SRAM_WORDS];
    logic [31:0]            lfsr_state;
    int                     word_errors;
    int                     flag_errors;
    int                     timeout_errors;

    tb_clock_gen i_tb_clock_gen (
        .o_clk (i_wb_clk)
    );

    wb_word_access i_wb_word_access (
        .i_wb_clk   (i_wb_clk),
        .i_wb_rst   (i_wb_rst),
        .i_drv_en   (i_drv_en),
        .i_drv_we   (i_drv_we),
        .i_drv_addr (i_drv_addr),
        .i_drv_data (i_drv_data),
        .o_drv_data (o_drv_data),
        .o_drv_done (o_drv_done),
        .o_drv_busy (o_drv_busy)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;   // Taps for x^32 + x^22 + x^2 + x + 1.
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Maps a byte address to its halfword slot with the same wrap as the SRAM.
    function automatic int sram_index(input wb_bus_pkg::wb_addr_t addr);
        return int'((addr / wb_bus_pkg::WB_BEAT_BYTES) % wb_bus_pkg::WB_SRAM_WORDS);
    endfunction

    function automatic drv_cmd_pkg::drv_data_t model_read(input wb_bus_pkg::wb_addr_t addr);
        return {shadow[sram_index(addr + 2)], shadow[sram_index(addr)]};
    endfunction

    task automatic model_write(input wb_bus_pkg::wb_addr_t addr,
                               input drv_cmd_pkg::drv_data_t data);
        shadow[sram_index(addr)]     = data[15:0];    // Low half goes first.
        shadow[sram_index(addr + 2)] = data[31:16];
    endtask

    task automatic add_row(input string name, input bit we, input wb_bus_pkg::wb_addr_t addr,
                           input bit lfsr, input drv_cmd_pkg::drv_data_t data,
                           input bit model, input drv_cmd_pkg::drv_data_t exp, input bit poke);
        row_name.push_back(name);
        row_we.push_back(we);
        row_addr.push_back(addr);
        row_lfsr.push_back(lfsr);
        row_data.push_back(data);
        row_model.push_back(model);
        row_exp.push_back(exp);
        row_poke.push_back(poke);
    endtask

    task automatic check_word(input string name, input drv_cmd_pkg::drv_data_t expected,
                              input drv_cmd_pkg::drv_data_t actual);
        if (actual !== expected) begin
            $display("Error %s: read word expected %h, actual %h", name, expected, actual);
            word_errors++;
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic expected,
                              input logic actual);
        if (actual !== expected) begin
            $display("Error %s: %s expected %b, actual %b", name, what, expected, actual);
            flag_errors++;
        end
    endtask

    task automatic build_table();
        wb_bus_pkg::wb_addr_t rand_addr [LFSR_ROWS];
        logic [31:0]          bits;
        add_row("fixed_wr", 1'b1, 32'h10, 1'b0, 32'h1234_abcd, 1'b0, '0, 1'b0);
        add_row("fixed_rd", 1'b0, 32'h10, 1'b0, '0, 1'b0, 32'h1234_abcd, 1'b0);
        add_row("adj_wr_lo", 1'b1, 32'h40, 1'b0, 32'hcafe_0001, 1'b0, '0, 1'b0);
        add_row("adj_wr_hi", 1'b1, 32'h44, 1'b0, 32'h5a5a_f00d, 1'b0, '0, 1'b0);
        add_row("adj_rd_lo", 1'b0, 32'h40, 1'b0, '0, 1'b0, 32'hcafe_0001, 1'b0);
        add_row("adj_rd_hi", 1'b0, 32'h44, 1'b0, '0, 1'b0, 32'h5a5a_f00d, 1'b0);
        add_row("adj_rd_mid", 1'b0, 32'h42, 1'b0, '0, 1'b1, '0, 1'b0);
        for (int i = 0; i < LFSR_ROWS; i++) begin
            take_bits(9, bits);
            rand_addr[i] = {bits[30:0], 1'b0};   // Addresses reach 1 KB so most of these wrap.
            add_row($sformatf("lfsr_wr_%0d", i), 1'b1, rand_addr[i], 1'b1, '0, 1'b0, '0, 1'b0);
        end
        for (int i = 0; i < LFSR_ROWS; i++) begin
            add_row($sformatf("lfsr_rd_%0d", i), 1'b0, rand_addr[i], 1'b0, '0, 1'b1, '0, 1'b0);
        end
        add_row("busy_rd_poke", 1'b0, 32'h10, 1'b0, 32'hdead_beef, 1'b1, '0, 1'b1);
        add_row("poke_check", 1'b0, 32'h10, 1'b0, '0, 1'b1, '0, 1'b0);
    endtask

    task automatic apply_row(input int r);
        drv_cmd_pkg::drv_data_t wdata;
        logic [31:0]            bits;
        bit                     got_done;
        int                     cycles;
        wdata = row_data[r];
        if (row_lfsr[r]) begin
            take_bits(32, bits);
            wdata = bits;
        end
        @(negedge i_wb_clk);
        i_drv_en   = 1'b1;
        i_drv_we   = row_we[r];
        i_drv_addr = row_addr[r];
        i_drv_data = wdata;
        if (row_we[r]) begin
            model_write(row_addr[r], wdata);
        end
        @(negedge i_wb_clk);
        i_drv_en = 1'b0;
        got_done = 1'b0;
        cycles   = 0;
        while (!got_done && cycles < DONE_TIMEOUT) begin
            check_flag(row_name[r], "busy", 1'b1, o_drv_busy);
            if (o_drv_done) begin
                got_done = 1'b1;
            end else begin
                if (row_poke[r] && cycles == 0) begin
                    i_drv_en   = 1'b1;   // A write that must not reach the memory.
                    i_drv_we   = 1'b1;
                    i_drv_data = row_data[r];
                end else begin
                    i_drv_en = 1'b0;
                end
                @(negedge i_wb_clk);
                cycles++;
            end
        end
        i_drv_en = 1'b0;
        if (!got_done) begin
            $display("Timeout: row %s saw no done pulse within %0d cycles",
                     row_name[r], DONE_TIMEOUT);
            timeout_errors++;
        end else begin
            if (!row_we[r]) begin
                check_word(row_name[r], row_model[r] ? model_read(row_addr[r]) : row_exp[r],
                           o_drv_data);
            end
            @(negedge i_wb_clk);
            check_flag(row_name[r], "busy", 1'b0, o_drv_busy);
            check_flag(row_name[r], "done", 1'b0, o_drv_done);
            if (row_poke[r]) begin
                for (int c = 0; c < 8; c++) begin
                    @(negedge i_wb_clk);
                    check_flag(row_name[r], "busy", 1'b0, o_drv_busy);
                    check_flag(row_name[r], "done", 1'b0, o_drv_done);
                end
            end
        end
    endtask

    initial begin
        i_wb_rst       = 1'b1;
        i_drv_en       = 1'b0;
        i_drv_we       = 1'b0;
        i_drv_addr     = '0;
        i_drv_data     = '0;
        lfsr_state     = 32'hc9a7_8c0d;
        word_errors    = 0;
        flag_errors    = 0;
        timeout_errors = 0;
        for (int i = 0; i < wb_bus_pkg::WB_SRAM_WORDS; i++) begin
            shadow[i] = wb_bus_pkg::wb_data_t'(i) ^ 16'ha5a5;
        end
        build_table();
        repeat (8) @(negedge i_wb_clk);
        i_wb_rst = 1'b0;
        for (int c = 0; c < 3; c++) begin
            @(negedge i_wb_clk);
            check_flag("reset_idle", "busy", 1'b0, o_drv_busy);
            check_flag("reset_idle", "done", 1'b0, o_drv_done);
        end
        for (int r = 0; r < row_name.size(); r++) begin
            apply_row(r);
        end
        $display("Errors: word %0d, flag %0d, timeout %0d",
                 word_errors, flag_errors, timeout_errors);
        if (word_errors + flag_errors + timeout_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/wb_bus_pkg.sv
logic/drv_cmd_pkg.sv
logic/wb_bus_if.sv
logic/wb_master_driver.sv
logic/wb_sram_slave.sv
logic/wb_word_access.sv
sim/tb_clock_gen.sv
sim/tb_wb_word_access.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_wb_word_access -f verilog.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qx "test passed" &&
exit 0 ||
exit 1
